/* logic/mult_consts.svh */
// multiplier widths and pipeline shape
`ifndef MULT_CONSTS_SVH
`define MULT_CONSTS_SVH

////////////////////////////////////////
// data widths
////////////////////////////////////////

`define MULT_WIDTH 16 // both operands
`define PROD_WIDTH 32 // twice the operand width

////////////////////////////////////////
// execute array split
////////////////////////////////////////

// one cass row per booth digit, NUM_STAGES * ROWS_PER_STAGE == MULT_WIDTH
`define ROWS_PER_STAGE 4
`define NUM_STAGES 4

`endif

/* logic/mult_types_pkg.sv */
// multiplier data types
`include "mult_consts.svh"

package mult_types_pkg;

	// operand words as seen at the top ports
	typedef logic signed [`MULT_WIDTH-1:0] operand_t;

	// full signed product
	typedef logic signed [`PROD_WIDTH-1:0] product_t;

	// running partial product
	// kept at full width from the first row, so no row needs its own size
	typedef logic signed [`PROD_WIDTH-1:0] acc_t;

endpackage

/* logic/booth_pkg.sv */
// booth recoding types
`include "mult_consts.svh"

package booth_pkg;

	import mult_types_pkg::*;

	////////////////////////////////////////
	// radix-2 booth digit
	////////////////////////////////////////

	// 2'b11 is never produced
	typedef enum logic [1:0] {
		BOOTH_NONE = 2'b00, // pair 00 or 11, shift only
		BOOTH_ADD  = 2'b01, // pair 01
		BOOTH_SUB  = 2'b10  // pair 10
	} booth_op_t;

	// index j holds the digit for row j
	typedef booth_op_t [`MULT_WIDTH-1:0] booth_digits_t;

	// one product in flight between stages
	typedef struct packed {
		logic          valid;
		operand_t      multiplicand;
		booth_digits_t digits;
		acc_t          acc;
	} stage_bundle_t;

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// pair is {b[j], b[j-1]}
	function automatic booth_op_t booth_encode(input logic [1:0] pair);
		booth_op_t op;
		case (pair)
			2'b01: op = BOOTH_ADD;
			2'b10: op = BOOTH_SUB;
			default: op = BOOTH_NONE;
		endcase
		return op;
	endfunction

	// true when every digit holds one of the three legal codes
	function automatic logic digits_legal(input booth_digits_t digits);
		logic ok;
		ok = 1'b1;
		for (int j = 0; j < `MULT_WIDTH; j++) begin
			if (2'(digits[j]) == 2'b11)
				ok = 1'b0;
		end
		return ok;
	endfunction

endpackage

/* logic/booth_recoder.sv */
// booth decode stage
`timescale 1ns/10ps
`include "mult_consts.svh"

module booth_recoder (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      in_valid,
	input  mult_types_pkg::operand_t  multiplicand,
	input  mult_types_pkg::operand_t  multiplier,
	output booth_pkg::stage_bundle_t  bundle
);

	import booth_pkg::*;

	logic [`MULT_WIDTH:0] mpr_ext;  // multiplier with bit -1 appended
	booth_digits_t        digits_next;

	////////////////////////////////////////
	// recoding
	////////////////////////////////////////

	assign mpr_ext = {multiplier, 1'b0}; // bit -1 is zero

	// every bit pair at once, one digit per cass row
	always_comb begin
		for (int j = 0; j < `MULT_WIDTH; j++) begin
			digits_next[j] = booth_encode(mpr_ext[j +: 2]);
		end
	end

	////////////////////////////////////////
	// output register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			bundle.valid <= 1'b0;
		end else begin
			bundle.valid <= in_valid;
		end
		bundle.multiplicand <= multiplicand;
		bundle.digits       <= digits_next;
		bundle.acc          <= '0; // array starts from an empty partial product
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// digits reach the execute stages only in legal codes
	a_digits_legal: assert property (
		@(posedge clk) disable iff (reset)
		bundle.valid |-> digits_legal(bundle.digits)
	) else $error("booth_recoder: illegal booth digit in valid bundle");

endmodule

/* logic/cass_stage.sv */
// cass execute stage
`timescale 1ns/10ps
`include "mult_consts.svh"

module cass_stage #(
	parameter int FIRST_ROW = 0  // 0, 4, 8 or 12
) (
	input  logic                      clk,
	input  logic                      reset,
	input  booth_pkg::stage_bundle_t  bundle_in,
	output booth_pkg::stage_bundle_t  bundle_out
);

	import mult_types_pkg::*;
	import booth_pkg::*;

	acc_t md_ext;                          // multiplicand sign-extended to full width
	acc_t row_acc [`ROWS_PER_STAGE+1];    // partial product after each row

	if (FIRST_ROW + `ROWS_PER_STAGE > `MULT_WIDTH) begin : g_bad_row
		$error("cass_stage: rows run past the last booth digit");
	end

	assign md_ext     = acc_t'(bundle_in.multiplicand);
	assign row_acc[0] = bundle_in.acc;

	////////////////////////////////////////
	// cass rows
	////////////////////////////////////////

	// each row picks +md, ~md with carry in, or zero, then adds it in
	for (genvar r = 0; r < `ROWS_PER_STAGE; r++) begin : g_row
		localparam int ROW = FIRST_ROW + r;

		acc_t row_md;  // multiplicand weighted for this row
		acc_t addend;
		logic cin;

		assign row_md = md_ext <<< ROW;

		always_comb begin
			case (bundle_in.digits[ROW])
				BOOTH_ADD: begin
					addend = row_md;
					cin    = 1'b0;
				end
				BOOTH_SUB: begin
					addend = ~row_md; // two's complement, finished by cin
					cin    = 1'b1;
				end
				default: begin
					addend = '0;
					cin    = 1'b0;
				end
			endcase
		end

		assign row_acc[r+1] = row_acc[r] + addend + {{(`PROD_WIDTH-1){1'b0}}, cin};
	end

	////////////////////////////////////////
	// output register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			bundle_out.valid <= 1'b0;
		end else begin
			bundle_out.valid <= bundle_in.valid;
		end
		bundle_out.multiplicand <= bundle_in.multiplicand;
		bundle_out.digits       <= bundle_in.digits; // later stages still need theirs
		bundle_out.acc          <= row_acc[`ROWS_PER_STAGE];
	end

	// no bubble turns into a result
	a_valid_origin: assert property (
		@(posedge clk) disable iff (reset)
		bundle_out.valid |-> $past(bundle_in.valid)
	) else $error("cass_stage %0d: valid out without valid in", FIRST_ROW);

endmodule

/* logic/product_assembler.sv */
// product result stage
`timescale 1ns/10ps
`include "mult_consts.svh"

module product_assembler (
	input  logic                      clk,
	input  logic                      reset,
	input  booth_pkg::stage_bundle_t  bundle,
	output logic                      out_valid,
	output mult_types_pkg::product_t  product
);

	import mult_types_pkg::*;

	// +2^30, only reached by -32768 squared
	localparam acc_t ACC_OVF = acc_t'({2'b01, {(`PROD_WIDTH-2){1'b0}}});

	logic     sign_bit;
	product_t product_next;

	////////////////////////////////////////
	// sign extension
	////////////////////////////////////////

	// array sum lives in bits 30:0, bit 30 repeated as the sign
	// except the one product that does not fit in 31 bits
	assign sign_bit     = (bundle.acc == ACC_OVF) ? 1'b0 : bundle.acc[`PROD_WIDTH-2];
	assign product_next = {sign_bit, bundle.acc[`PROD_WIDTH-2:0]};

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= bundle.valid;
		end
		product <= product_next;
	end

	// pipeline flush shows at the port right after reset
	a_quiet_after_reset: assert property (
		@(posedge clk)
		reset |=> !out_valid
	) else $error("product_assembler: out_valid high after reset");

endmodule

/* logic/booth_mult_top.sv */
// pipelined booth array multiplier
`timescale 1ns/10ps
`include "mult_consts.svh"

module booth_mult_top (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      in_valid,
	input  mult_types_pkg::operand_t  multiplicand,
	input  mult_types_pkg::operand_t  multiplier,
	output logic                      out_valid,
	output mult_types_pkg::product_t  product
);

	import booth_pkg::*;

	// chain[0] from decode, chain[k+1] from execute stage k
	stage_bundle_t chain [`NUM_STAGES+1];

	////////////////////////////////////////
	// decode
	////////////////////////////////////////

	booth_recoder u_decode (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.bundle       (chain[0])
	);

	////////////////////////////////////////
	// execute, four rows per stage
	////////////////////////////////////////

	for (genvar k = 0; k < `NUM_STAGES; k++) begin : g_stage
		cass_stage #(
			.FIRST_ROW (k * `ROWS_PER_STAGE)
		) u_exec (
			.clk        (clk),
			.reset      (reset),
			.bundle_in  (chain[k]),
			.bundle_out (chain[k+1])
		);
	end

	////////////////////////////////////////
	// result
	////////////////////////////////////////

	product_assembler u_result (
		.clk       (clk),
		.reset     (reset),
		.bundle    (chain[`NUM_STAGES]),
		.out_valid (out_valid),
		.product   (product)
	);

endmodule

/* test/booth_mult_tb.sv */
// booth multiplier testbench
`timescale 1ns/10ps
`include "mult_consts.svh"

module booth_mult_tb;

	import mult_types_pkg::*;

	localparam int LATENCY      = `NUM_STAGES + 2; // decode + execute + result
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_PAIRS = 200;
	localparam int CORNER_PAIRS = 10;
	localparam int GAP_PAIRS    = 100;
	// gapped pairs take at most three cycles each, reset phase about 30
	localparam int MAX_CYCLES = RESET_CYCLES + RANDOM_PAIRS + CORNER_PAIRS +
		3 * GAP_PAIRS + 30 + 4 * (LATENCY + 2) + 50;

	// one expected result and the cycle it must show up in
	typedef struct packed {
		int       due;
		product_t value;
	} expect_t;

	logic     clk;
	logic     reset;
	logic     in_valid;
	operand_t multiplicand;
	operand_t multiplier;
	logic     out_valid;
	product_t product;

	expect_t     exp_q [$];
	expect_t     head        = '0;
	logic        head_valid  = 1'b0;
	logic        reset_seen  = 1'b0; // reset was high at the last rising edge
	int          cycle       = 0;
	int          value_errors    = 0;
	int          protocol_errors = 0;
	logic [31:0] rng         = 32'd6724;
	string       test_name   = "reset";

	booth_mult_top dut0 (
		.clk          (clk),
		.reset        (reset),
		.in_valid     (in_valid),
		.multiplicand (multiplicand),
		.multiplier   (multiplier),
		.out_valid    (out_valid),
		.product      (product)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic operand_t random_operand();
		rng = next_random(rng);
		return operand_t'(rng[23:8]);
	endfunction

	// plain signed product of the two operands
	function automatic product_t expected_product(input operand_t a, input operand_t b);
		return product_t'(a) * product_t'(b);
	endfunction

	task automatic drive_pair(input operand_t a, input operand_t b);
		@(negedge clk);
		in_valid     = 1'b1;
		multiplicand = a;
		multiplier   = b;
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic drain_results();
		idle_cycle();
		while (head_valid)
			idle_cycle();
	endtask

	////////////////////////////////////////
	// reference queue
	////////////////////////////////////////

	// updated on the rising edge only, so every check sees settled values
	always @(posedge clk) begin : track_queue
		expect_t entry;
		cycle      = cycle + 1;
		reset_seen = reset;
		if (head_valid && head.due < cycle)
			void'(exp_q.pop_front()); // already checked last falling edge
		if (reset) begin
			exp_q.delete(); // in-flight results are dropped too
		end else if (in_valid) begin
			// out_valid rises on the edge LATENCY-1 later, sampled on the next
			entry.due   = cycle + LATENCY - 1;
			entry.value = expected_product(multiplicand, multiplier);
			exp_q.push_back(entry);
		end
		head_valid = exp_q.size() != 0;
		if (head_valid)
			head = exp_q[0];
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	a_reset_quiet: assert property (@(negedge clk) reset_seen |-> !out_valid)
		else begin
			protocol_errors++;
			$display("out_valid high right after a reset edge at cycle %0d", cycle);
		end

	a_no_extra: assert property (@(negedge clk) out_valid |-> head_valid)
		else begin
			protocol_errors++;
			$display("out_valid at cycle %0d with no pair in flight", cycle);
		end

	a_on_time: assert property (@(negedge clk) out_valid && head_valid |-> head.due == cycle)
		else begin
			protocol_errors++;
			$display("result at cycle %0d, next one due at cycle %0d", cycle, head.due);
		end

	a_not_missing: assert property (@(negedge clk) head_valid && head.due == cycle |-> out_valid)
		else begin
			protocol_errors++;
			$display("no result at cycle %0d where one was due", cycle);
		end

	a_product: assert property (@(negedge clk)
		out_valid && head_valid && head.due == cycle |-> product == head.value)
		else begin
			value_errors++;
			$display("FAIL %s: expected %0d, actual %0d", test_name,
				$signed(head.value), $signed(product));
		end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	initial begin : stimulus
		int gap;
		reset        = 1'b1;
		in_valid     = 1'b0;
		multiplicand = '0;
		multiplier   = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;

		test_name = "random";
		repeat (RANDOM_PAIRS) drive_pair(random_operand(), random_operand());
		drain_results();

		test_name = "corner";
		drive_pair(-16'sd32768, -16'sd32768); // only product needing bit 31 clear
		drive_pair(-16'sd32768, 16'sd32767);
		drive_pair(16'sd0, random_operand());
		drive_pair(random_operand(), 16'sd0);
		drive_pair(-16'sd1, -16'sd1);
		drive_pair(16'sd32767, 16'sd32767);
		drive_pair(random_operand(), operand_t'(16'h5555)); // every row active
		drive_pair(random_operand(), operand_t'(16'hAAAA));
		drive_pair(operand_t'(16'h5555), operand_t'(16'hAAAA));
		drive_pair(-16'sd32768, operand_t'(16'hAAAA));
		drain_results();

		test_name = "gapped";
		repeat (GAP_PAIRS) begin
			rng = next_random(rng);
			gap = int'(rng[1:0]);
			if (gap == 3)
				gap = 1; // 0..2 idle cycles, about half duty
			repeat (gap) idle_cycle();
			drive_pair(random_operand(), random_operand());
		end
		drain_results();

		test_name = "reset";
		repeat (8) drive_pair(random_operand(), random_operand());
		@(negedge clk);
		in_valid = 1'b0;
		reset    = 1'b1;
		@(negedge clk);
		reset = 1'b0;
		repeat (8) idle_cycle(); // pipeline must stay quiet here
		repeat (4) drive_pair(random_operand(), random_operand());
		drain_results();

		$display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
		if (value_errors + protocol_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin : watchdog
		wait (cycle >= MAX_CYCLES);
		$display("run stopped by timeout after %0d cycles", cycle);
		$display("Test failed");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+logic
logic/mult_types_pkg.sv
logic/booth_pkg.sv
logic/booth_recoder.sv
logic/cass_stage.sv
logic/product_assembler.sv
logic/booth_mult_top.sv
test/booth_mult_tb.sv

/* Makefile */
TOP := booth_mult_tb

.PHONY: sim clean

# build and run; pass only if the pass line shows up in the output
sim:
	verilator --binary --assert --top-module $(TOP) -f verilog.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir
